//--- hdl/cntPkg.sv
`default_nettype none

package cntPkg;

	// refresh interval position, counts 0..10 on E falls
	typedef logic [3:0] refCntT;

	// long interval position, one step per refresh wrap
	typedef logic [11:0] longCntT;

	// remaining QoS window in refresh intervals
	typedef logic [3:0] qosCntT;

	// QoS timeout setting from the board jumpers
	typedef logic [3:0] slowTimeoutT; // zero keeps QoS always on

	// startup machine
	typedef enum logic [1:0] {
		stHold0,   // host in reset, bus requested
		stHold1,   // still holding
		stNmiWait, // NMI press here gives the bus back
		stRun      // normal operation
	} startStateT;

	// refresh interval, 11 positions
	localparam refCntT REF_LAST = 4'd10;
	localparam refCntT REF_URG_FROM = 4'd8; // urgent from here up to REF_LAST

	// window loaded on every slow select
	localparam qosCntT QOS_RELOAD = 4'd15;

	// long interval, 4096 refresh wraps
	localparam longCntT LONG_LAST = 12'd4095;

endpackage

`default_nettype wire

//--- hdl/hostClkMon.sv
`timescale 1ns/100ps
`default_nettype none

module hostClkMon (
	input  wire  CLK,
	input  wire  arstN,
	input  wire  E,       // host E clock, async to CLK
	input  wire  C8M,     // host 8 MHz clock, async to CLK
	output logic eFall,   // one CLK per E falling edge
	output logic c8mFall, // one CLK per C8M falling edge
	output logic nPOR     // low while C8M is stuck
);

	logic [1:0] eSr;   // E synchronizer, [0] is newest
	logic [3:0] c8mSr; // C8M synchronizer plus history for stall check

	// E sync chain
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			eSr <= '0;
		end else begin
			eSr <= {eSr[0], E};
		end
	end

	// C8M sync chain, four deep so a stopped clock shows up
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			c8mSr <= '0;
		end else begin
			c8mSr <= {c8mSr[2:0], C8M};
		end
	end

	// falling edges from the two oldest-but-one stages
	assign eFall = eSr[1] && !eSr[0];
	assign c8mFall = c8mSr[1] && !c8mSr[0];

	// power-on reset tracks C8M activity
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			nPOR <= 1'b0; // hold host reset from the start
		end else if (c8mSr == 4'b0000 || c8mSr == 4'b1111) begin
			nPOR <= 1'b0; // four equal samples, host clock stopped
		end else if (c8mSr[1:0] == 2'b01) begin
			nPOR <= 1'b1; // rising edge seen again
		end
	end

endmodule

`default_nettype wire

//--- hdl/refreshTimer.sv
`timescale 1ns/100ps
`default_nettype none

module refreshTimer (
	input  wire  CLK,
	input  wire  arstN,
	input  wire  eFall,   // E falling edge strobe
	output logic RefReq,  // refresh wanted
	output logic RefUrg,  // refresh overdue
	output logic refTick, // refresh interval wrapped
	output logic longTick // long interval wrapped
);

	import cntPkg::*;

	refCntT  refPos;  // position inside refresh interval
	longCntT longPos; // position inside long interval
	logic    refWrap; // last refresh position on this E fall
	logic    longWrap;

	assign refWrap = eFall && (refPos == REF_LAST);
	assign longWrap = refTick && (longPos == LONG_LAST);

	// refresh interval, about 14 us at 11 E periods
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			refPos <= '0;
			RefReq <= 1'b0;
			RefUrg <= 1'b0;
		end else if (eFall) begin
			if (refPos == REF_LAST) begin
				refPos <= '0;
			end else begin
				refPos <= refPos + 1'b1;
			end
			// levels come from the old position
			RefReq <= refPos != REF_LAST;
			RefUrg <= (refPos >= REF_URG_FROM) && (refPos != REF_LAST);
		end
	end

	// long interval, 4096 refresh wraps, roughly 57 ms
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			longPos <= '0;
		end else if (refTick) begin
			if (longPos == LONG_LAST) begin
				longPos <= '0;
			end else begin
				longPos <= longPos + 1'b1;
			end
		end
	end

	// both ticks registered, one cycle behind their cause
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			refTick <= 1'b0;
			longTick <= 1'b0;
		end else begin
			refTick <= refWrap;
			longTick <= longWrap;
		end
	end

endmodule

`default_nettype wire

//--- hdl/qosCtl.sv
`timescale 1ns/100ps
`default_nettype none

module qosCtl (
	input  wire                 CLK,
	input  wire                 arstN,
	input  wire                 refTick,       // drains the window
	input  wire                 c8mFall,       // lets one CPU clock through
	input  wire                 nAS,           // CPU address strobe
	input  wire                 ASrf,          // refresh access in progress
	input  wire                 BACT,          // bus cycle active
	input  wire                 nRESin,        // reset button
	input  wire                 IACKCS,
	input  wire                 VIACS,
	input  wire                 IWMCS,
	input  wire                 SCCCS,
	input  wire                 SCSICS,
	input  wire                 SndCSWR,       // sound buffer write
	input  wire                 SlowIACK,
	input  wire                 SlowVIA,
	input  wire                 SlowIWM,
	input  wire                 SlowSCC,
	input  wire                 SlowSCSI,
	input  wire                 SlowSnd,
	input  wire                 SlowClockGate, // low disables clock gating
	input  cntPkg::slowTimeoutT SlowTimeout,
	output logic                QoSEN,
	output logic                MCKE           // CPU clock enable
);

	import cntPkg::*;

	logic   slowHit;  // registered slow select
	logic   anySlow;  // some enabled slow device selected now
	qosCntT qosCnt;   // window left, in refresh intervals
	logic   mckeSetN; // async set of MCKE

	// selects only count during an active cycle
	assign anySlow = BACT && (
		(SlowIACK && IACKCS) ||
		(SlowVIA  && VIACS)  ||
		(SlowIWM  && IWMCS)  ||
		(SlowSCC  && SCCCS)  ||
		(SlowSCSI && SCSICS) ||
		(SlowSnd  && SndCSWR));

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			slowHit <= 1'b0;
		end else begin
			slowHit <= !nRESin || anySlow; // button press also opens window
		end
	end

	// window counter, reload wins over drain
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			qosCnt <= '0;
		end else if (slowHit) begin
			qosCnt <= QOS_RELOAD;
		end else if (refTick && qosCnt != '0) begin
			qosCnt <= qosCnt - 1'b1;
		end
	end

	// only change QoSEN between bus cycles
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			QoSEN <= 1'b0;
		end else if (!BACT) begin
			QoSEN <= (qosCnt != '0) || (SlowTimeout == '0);
		end
	end

	// address strobe or board reset forces the clock on
	assign mckeSetN = arstN && nAS;

	// CPU clock gating on falling CLK
	always_ff @(negedge CLK or negedge mckeSetN) begin
		if (!mckeSetN) begin
			MCKE <= 1'b1;
		end else begin
			MCKE <= ASrf || !QoSEN || c8mFall || !SlowClockGate;
		end
	end

endmodule

`default_nettype wire

//--- hdl/startupSeq.sv
`timescale 1ns/100ps
`default_nettype none

module startupSeq (
	input  wire  CLK,
	input  wire  arstN,
	input  wire  nPOR,     // restarts the sequence while low
	input  wire  longTick, // paces the sequence
	input  wire  nIPL2,    // low while NMI button held
	output logic nRESout,  // host reset
	output logic nBR_IOB,  // bus request, low requests
	output logic AoutOE    // PDS address and control drivers
);

	import cntPkg::*;

	startStateT state;

	// state walk, one step per long interval
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			state <= stHold0;
		end else if (!nPOR) begin
			state <= stHold0; // host clock lost, start over
		end else begin
			case (state)
				stHold0: if (longTick) state <= stHold1;
				stHold1: if (longTick) state <= stNmiWait;
				stNmiWait: if (longTick && nIPL2) state <= stRun; // wait out NMI
				stRun: state <= stRun;
				default: state <= stHold0;
			endcase
		end
	end

	// registered outputs per state
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			nRESout <= 1'b0;
			nBR_IOB <= 1'b0;
			AoutOE <= 1'b0;
		end else begin
			case (state)
				stHold0, stHold1: begin
					nRESout <= 1'b0; // host held in reset
					nBR_IOB <= 1'b0; // ask for the bus
					AoutOE <= 1'b0;  // drivers off
				end
				stNmiWait: begin
					nRESout <= 1'b0;
					AoutOE <= 1'b0;
					if (!nIPL2) nBR_IOB <= 1'b1; // NMI press, leave bus to host
				end
				default: begin
					AoutOE <= !nBR_IOB; // drive only if we own the bus
					if (longTick) nRESout <= 1'b1; // let host run
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hdl/cntTop.sv
`timescale 1ns/100ps
`default_nettype none

module cntTop (
	input  wire                 CLK,
	input  wire                 arstN,
	// host clocks
	input  wire                 E,
	input  wire                 C8M,
	output wire                 nPOR,
	// refresh
	output wire                 RefReq,
	output wire                 RefUrg,
	// reset, NMI and bus mastering
	output wire                 nRESout,
	input  wire                 nRESin,
	input  wire                 nIPL2,
	output wire                 AoutOE,
	output wire                 nBR_IOB,
	// bus status
	input  wire                 nAS,
	input  wire                 ASrf,
	input  wire                 BACT,
	// chip selects from the decoder
	input  wire                 IACKCS,
	input  wire                 VIACS,
	input  wire                 IWMCS,
	input  wire                 SCCCS,
	input  wire                 SCSICS,
	input  wire                 SndCSWR,
	// QoS settings
	input  wire                 SlowIACK,
	input  wire                 SlowVIA,
	input  wire                 SlowIWM,
	input  wire                 SlowSCC,
	input  wire                 SlowSCSI,
	input  wire                 SlowSnd,
	input  wire                 SlowClockGate,
	input  cntPkg::slowTimeoutT SlowTimeout,
	// QoS outputs
	output wire                 QoSEN,
	output wire                 MCKE
);

	wire eFall;    // E falling edge
	wire c8mFall;  // C8M falling edge
	wire refTick;  // refresh interval wrap
	wire longTick; // long interval wrap

	hostClkMon i_hostClkMon (
		.CLK(CLK), .arstN(arstN),
		.E(E), .C8M(C8M),
		.eFall(eFall), .c8mFall(c8mFall), .nPOR(nPOR)
	);

	refreshTimer i_refreshTimer (
		.CLK(CLK), .arstN(arstN), .eFall(eFall),
		.RefReq(RefReq), .RefUrg(RefUrg),
		.refTick(refTick), .longTick(longTick)
	);

	qosCtl i_qosCtl (
		.CLK(CLK), .arstN(arstN),
		.refTick(refTick), .c8mFall(c8mFall),
		.nAS(nAS), .ASrf(ASrf), .BACT(BACT), .nRESin(nRESin),
		.IACKCS(IACKCS), .VIACS(VIACS), .IWMCS(IWMCS),
		.SCCCS(SCCCS), .SCSICS(SCSICS), .SndCSWR(SndCSWR),
		.SlowIACK(SlowIACK), .SlowVIA(SlowVIA), .SlowIWM(SlowIWM),
		.SlowSCC(SlowSCC), .SlowSCSI(SlowSCSI), .SlowSnd(SlowSnd),
		.SlowClockGate(SlowClockGate), .SlowTimeout(SlowTimeout),
		.QoSEN(QoSEN), .MCKE(MCKE)
	);

	startupSeq i_startupSeq (
		.CLK(CLK), .arstN(arstN),
		.nPOR(nPOR), .longTick(longTick), .nIPL2(nIPL2),
		.nRESout(nRESout), .nBR_IOB(nBR_IOB), .AoutOE(AoutOE)
	);

endmodule

`default_nettype wire

//--- test/cntTb.sv
`timescale 1ns/100ps
`default_nettype none

module cntTb;

	import cntPkg::*;

	localparam int CLK_NS = 40;
	localparam longint RUN_CYCLES = 9 * 4096 * 11 * 4; // startups of 4 and 5 long ticks
	localparam longint WATCH_NS = (RUN_CYCLES + 50000) * CLK_NS;

	logic CLK;
	logic arstN, nRESin, nIPL2, nAS, ASrf, BACT;
	logic IACKCS, VIACS, IWMCS, SCCCS, SCSICS, SndCSWR;
	logic SlowIACK, SlowVIA, SlowIWM, SlowSCC, SlowSCSI, SlowSnd, SlowClockGate;
	slowTimeoutT SlowTimeout;
	logic E = 1'b0;
	logic C8M = 1'b0;
	logic [1:0] ePhase = 2'd0; // E is CLK/4
	logic c8mRun;              // low stalls C8M
	wire nPOR, RefReq, RefUrg, nRESout, AoutOE, nBR_IOB, QoSEN, MCKE;

	int autoErrs = 0; // from the compare process
	int dirErrs = 0;  // from directed tests

	// model state
	logic [1:0] mE;
	logic [3:0] mC;
	refCntT mPos;
	longCntT mLong;
	qosCntT mQos;
	startStateT mState;
	logic mRefTick, mLongTick, mHit;
	logic expReq, expUrg, expPor, expQosen, expRes, expBr, expOe;

	cntTop i_cntTop (
		.CLK(CLK), .arstN(arstN), .E(E), .C8M(C8M), .nPOR(nPOR),
		.RefReq(RefReq), .RefUrg(RefUrg),
		.nRESout(nRESout), .nRESin(nRESin), .nIPL2(nIPL2),
		.AoutOE(AoutOE), .nBR_IOB(nBR_IOB),
		.nAS(nAS), .ASrf(ASrf), .BACT(BACT),
		.IACKCS(IACKCS), .VIACS(VIACS), .IWMCS(IWMCS),
		.SCCCS(SCCCS), .SCSICS(SCSICS), .SndCSWR(SndCSWR),
		.SlowIACK(SlowIACK), .SlowVIA(SlowVIA), .SlowIWM(SlowIWM),
		.SlowSCC(SlowSCC), .SlowSCSI(SlowSCSI), .SlowSnd(SlowSnd),
		.SlowClockGate(SlowClockGate), .SlowTimeout(SlowTimeout),
		.QoSEN(QoSEN), .MCKE(MCKE)
	);

	initial begin
		CLK = 1'b0;
		forever #(CLK_NS / 2) CLK = ~CLK;
	end

	// host clocks, E 2 high 2 low, C8M toggles each cycle
	always @(posedge CLK) begin
		ePhase <= ePhase + 2'd1;
		E <= !ePhase[1];
		if (c8mRun) C8M <= !C8M;
	end

	// refresh table: {RefReq, RefUrg} for the position before its step
	function automatic logic [1:0] refLevels(input refCntT pos);
		refLevels[1] = (pos != 4'd10);
		refLevels[0] = (pos == 4'd8) || (pos == 4'd9);
	endfunction

	function automatic logic qosLevel(input qosCntT cnt, input slowTimeoutT tmo);
		qosLevel = (cnt != 4'd0) || (tmo == 4'd0); // zero timeout = always on
	endfunction

	function automatic logic mckeLevel(input logic as, rf, qos, c8f, gate);
		if (!as) mckeLevel = 1'b1; // strobe forces clock
		else mckeLevel = rf || !qos || c8f || !gate;
	endfunction

	// startup state as seen from the pins, hold states look the same
	function automatic startStateT outState(input logic res, br, oe);
		if (res || oe) outState = stRun;
		else if (br) outState = stNmiWait;
		else outState = stHold0;
	endfunction

	// reference model, fed from the same pins the testbench drives
	always @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			mE <= '0;
			mC <= '0;
			mPos <= '0;
			mLong <= '0;
			mQos <= '0;
			mState <= stHold0;
			{mRefTick, mLongTick, mHit} <= '0;
			{expReq, expUrg, expPor, expQosen} <= '0;
			{expRes, expBr, expOe} <= '0;
		end else begin
			mE <= {mE[0], E};
			mC <= {mC[2:0], C8M};
			if (mE == 2'b10) begin // synced E fall
				{expReq, expUrg} <= refLevels(mPos);
				mPos <= (mPos == 4'd10) ? 4'd0 : mPos + 4'd1;
			end
			mRefTick <= (mE == 2'b10) && (mPos == 4'd10);
			if (mRefTick) mLong <= mLong + 12'd1; // wraps at 4096
			mLongTick <= mRefTick && (mLong == 12'd4095);
			if (mC == 4'b0000 || mC == 4'b1111) expPor <= 1'b0;
			else if (mC[1:0] == 2'b01) expPor <= 1'b1;
			mHit <= !nRESin || (BACT && ((SlowIACK && IACKCS) || (SlowVIA && VIACS)
				|| (SlowIWM && IWMCS) || (SlowSCC && SCCCS)
				|| (SlowSCSI && SCSICS) || (SlowSnd && SndCSWR)));
			if (mHit) mQos <= 4'd15;
			else if (mRefTick && mQos != 4'd0) mQos <= mQos - 4'd1;
			if (!BACT) expQosen <= qosLevel(mQos, SlowTimeout);
			if (!expPor) mState <= stHold0;
			else if (mState == stHold0 && mLongTick) mState <= stHold1;
			else if (mState == stHold1 && mLongTick) mState <= stNmiWait;
			else if (mState == stNmiWait && mLongTick && nIPL2) mState <= stRun;
			case (mState)
				stHold0, stHold1: {expRes, expBr, expOe} <= 3'b000;
				stNmiWait: begin
					expRes <= 1'b0;
					expOe <= 1'b0;
					if (!nIPL2) expBr <= 1'b1; // NMI gives bus back
				end
				default: begin
					expOe <= !expBr;
					if (mLongTick) expRes <= 1'b1;
				end
			endcase
		end
	end

	task automatic checkBit(input logic got, input logic exp, input string what,
		inout int errs);
		if (got !== exp) begin
			errs++;
			$display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic checkState(input startStateT got, input startStateT exp,
		inout int errs);
		if (got !== exp) begin
			errs++;
			$display("MISMATCH at %0t: startup state %s, expected %s", $time,
				got.name(), exp.name());
		end
	endtask

	// compare just after the falling edge, MCKE has settled by then
	always @(negedge CLK) begin
		#1;
		if (arstN) begin
			checkBit(nPOR, expPor, "nPOR", autoErrs);
			checkBit(RefReq, expReq, "RefReq", autoErrs);
			checkBit(RefUrg, expUrg, "RefUrg", autoErrs);
			checkBit(QoSEN, expQosen, "QoSEN", autoErrs);
			checkBit(nRESout, expRes, "nRESout", autoErrs);
			checkBit(nBR_IOB, expBr, "nBR_IOB", autoErrs);
			checkBit(AoutOE, expOe, "AoutOE", autoErrs);
			checkBit(MCKE, mckeLevel(nAS, ASrf, expQosen, mC[1] && !mC[0], SlowClockGate),
				"MCKE", autoErrs);
			checkState(outState(nRESout, nBR_IOB, AoutOE), outState(expRes, expBr, expOe),
				autoErrs);
		end
	end

	initial begin
		#(WATCH_NS);
		$display("timeout: the run did not finish in the expected time");
		$display("TEST FAILED");
		$finish;
	end

	task automatic idleCycles(input int n);
		repeat (n) @(posedge CLK);
	endtask

	// one cycle of random bus traffic, selects are sparse
	task automatic trafficCycle;
		logic [31:0] r;
		r = $urandom;
		@(posedge CLK);
		BACT <= r[0];
		nAS <= r[1] | r[2];
		ASrf <= r[3] & r[4];
		SlowClockGate <= r[24] | r[25];
		if (r[11:6] == 6'd0) begin
			{IACKCS, VIACS, IWMCS, SCCCS, SCSICS, SndCSWR} <= r[17:12];
			{SlowIACK, SlowVIA, SlowIWM, SlowSCC, SlowSCSI, SlowSnd} <= r[23:18];
			nRESin <= r[26] | r[27]; // occasional button press
		end else begin
			{IACKCS, VIACS, IWMCS, SCCCS, SCSICS, SndCSWR} <= 6'd0;
			nRESin <= 1'b1;
		end
	endtask

	task automatic waitLongTick;
		do trafficCycle(); while (!mLongTick);
	endtask

	task automatic quietBus;
		@(posedge CLK);
		{IACKCS, VIACS, IWMCS, SCCCS, SCSICS, SndCSWR} <= 6'd0;
		{SlowIACK, SlowVIA, SlowIWM, SlowSCC, SlowSCSI, SlowSnd} <= 6'd0;
		{BACT, ASrf} <= 2'b00;
		nAS <= 1'b1;
		nRESin <= 1'b1;
		SlowClockGate <= 1'b1;
	endtask

	task automatic porTest;
		int n;
		@(posedge CLK);
		c8mRun <= 1'b0; // stall host clock
		n = 0;
		while (nPOR && n < 8) begin
			@(posedge CLK);
			n++;
		end
		if (nPOR) begin
			dirErrs++;
			$display("nPOR stayed high after C8M stopped");
		end
		idleCycles(10);
		c8mRun <= 1'b1;
		n = 0;
		while (!nPOR && n < 8) begin
			@(posedge CLK);
			n++;
		end
		if (!nPOR) begin
			dirErrs++;
			$display("nPOR did not return high after C8M restarted");
		end
	endtask

	task automatic qosWindowTest;
		int n;
		int ticks;
		@(posedge CLK);
		{SlowVIA, VIACS, BACT} <= 3'b111; // slow VIA access
		@(posedge CLK);
		{VIACS, BACT} <= 2'b00;
		n = 0;
		while (!QoSEN && n < 20) begin
			@(posedge CLK);
			n++;
		end
		if (!QoSEN) begin
			dirErrs++;
			$display("QoSEN did not rise after a slow VIA select");
		end
		// find a gated cycle first
		n = 0;
		@(posedge CLK);
		while (MCKE && n < 4) begin
			@(posedge CLK);
			n++;
		end
		nAS <= 1'b0; // only the async set can raise MCKE before the next fall
		#1 checkBit(MCKE, 1'b1, "MCKE with nAS low", dirErrs);
		@(posedge CLK);
		nAS <= 1'b1;
		ticks = 0;
		while (QoSEN && ticks < 20) begin
			@(posedge CLK);
			if (mRefTick) ticks++;
		end
		if (ticks < 14 || ticks > 16) begin
			dirErrs++;
			$display("MISMATCH at %0t: QoS window lasted %0d refresh ticks, expected 14 to 16",
				$time, ticks);
		end
		// slow bit clear, window stays shut
		{SlowVIA, VIACS, BACT} <= 3'b011;
		@(posedge CLK);
		{VIACS, BACT} <= 2'b00;
		idleCycles(10);
		checkBit(QoSEN, 1'b0, "QoSEN after fast select", dirErrs);
		SlowTimeout <= 4'd0;
		idleCycles(5);
		checkBit(QoSEN, 1'b1, "QoSEN with zero timeout", dirErrs);
		SlowTimeout <= 4'd5;
		idleCycles(5);
	endtask

	initial begin
		void'($urandom(32'he980));
		arstN <= 1'b0;
		{nRESin, nIPL2, nAS, c8mRun, SlowClockGate} <= 5'b11111;
		{ASrf, BACT} <= 2'b00;
		{IACKCS, VIACS, IWMCS, SCCCS, SCSICS, SndCSWR} <= 6'd0;
		{SlowIACK, SlowVIA, SlowIWM, SlowSCC, SlowSCSI, SlowSnd} <= 6'd0;
		SlowTimeout <= 4'd5;
		idleCycles(10);
		arstN <= 1'b1;
		idleCycles(20);
		porTest();
		idleCycles(20);
		qosWindowTest();
		// startup without NMI, random traffic meanwhile
		waitLongTick();
		checkBit(nRESout, 1'b0, "nRESout after first long tick", dirErrs);
		waitLongTick();
		checkBit(AoutOE, 1'b0, "AoutOE after second long tick", dirErrs);
		waitLongTick();
		idleCycles(3);
		checkBit(AoutOE, 1'b1, "AoutOE in run", dirErrs);
		waitLongTick();
		idleCycles(3);
		checkBit(nRESout, 1'b1, "nRESout after fourth long tick", dirErrs);
		// second startup, NMI held while waiting
		quietBus();
		arstN <= 1'b0;
		idleCycles(10);
		arstN <= 1'b1;
		waitLongTick();
		waitLongTick();
		nIPL2 <= 1'b0;
		idleCycles(20);
		checkBit(nBR_IOB, 1'b1, "nBR_IOB after NMI", dirErrs);
		waitLongTick(); // NMI still held, machine keeps waiting
		nIPL2 <= 1'b1;
		waitLongTick();
		idleCycles(3);
		checkBit(AoutOE, 1'b0, "AoutOE without bus", dirErrs);
		checkBit(nRESout, 1'b0, "nRESout on entering run", dirErrs);
		waitLongTick();
		idleCycles(3);
		checkBit(nRESout, 1'b1, "nRESout after NMI startup", dirErrs);
		checkBit(AoutOE, 1'b0, "AoutOE after NMI startup", dirErrs);
		$display("compare errors: %0d, directed errors: %0d", autoErrs, dirErrs);
		if (autoErrs == 0 && dirErrs == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
hdl/cntPkg.sv
hdl/hostClkMon.sv
hdl/refreshTimer.sv
hdl/qosCtl.sv
hdl/startupSeq.sv
hdl/cntTop.sv
test/cntTb.sv

//--- sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass line in the log
rm -rf obj_dir sim.log

verilator --binary --timing -f src.f --top-module cntTb -o cntSim \
	&& ./obj_dir/cntSim > sim.log 2>&1

grep -q "^TEST OK$" sim.log \
	&& { echo "simulation passed"; exit 0; } \
	|| { echo "simulation failed, see sim.log"; exit 1; }
